// File: rtl/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// ========================================
// Line and slot geometry
// ========================================
`define FETCH_SLOTS        4
`define FETCH_SLOT_W       32
`define FETCH_LINE_W       128
`define FETCH_ADDR_W       32
`define FETCH_BNO_W        6
// Byte offset bits within one line (16 bytes per line)
`define FETCH_LINE_OFS_W   4

// ========================================
// Cache, credits and reset behaviour
// ========================================
`define FETCH_IC_LINES     16
`define FETCH_IC_IDX_W     4
`define FETCH_CREDITS      4
`define FETCH_CREDIT_W     3
`define FETCH_RST_PC       32'h0000_0100
`define FETCH_RSTCNT_CYC   4
`define FETCH_RSTCNT_W     3
// Encoding of the no-operation instruction used for squashed lines
`define FETCH_OP_NOP       32'h0000_0013

`endif

// File: rtl/fetch_pkg.sv
`default_nettype none

`include "fetch_consts.svh"

package fetch_pkg;

	// ========================================
	// Plain vectors with a meaning
	// ========================================
	typedef logic [`FETCH_ADDR_W-1:0] fetch_addr_t;
	typedef logic [`FETCH_BNO_W-1:0] fetch_bno_t;
	typedef logic [`FETCH_SLOT_W-1:0] fetch_insn_t;
	typedef logic [2:0] fetch_irq_t;
	typedef logic [`FETCH_CREDIT_W-1:0] fetch_credit_t;
	typedef logic [`FETCH_IC_IDX_W-1:0] fetch_ic_idx_t;
	typedef logic [`FETCH_ADDR_W-`FETCH_IC_IDX_W-`FETCH_LINE_OFS_W-1:0] fetch_ic_tag_t;

	// Slot 0 sits in the least significant word of the line
	typedef fetch_insn_t [`FETCH_SLOTS-1:0] fetch_line_t;

	// ========================================
	// Structured signals
	// ========================================
	// Fetch address together with the taken and fall-through branch numbers
	typedef struct packed {
		fetch_addr_t pc;
		fetch_bno_t  bno_t;
		fetch_bno_t  bno_f;
	} fetch_pc_t;

	typedef struct packed {
		logic      valid;
		fetch_pc_t target;
	} fetch_redirect_t;

	// The address is line aligned so its low offset bits are always zero
	typedef struct packed {
		logic        valid;
		fetch_addr_t addr;
	} fetch_mem_req_t;

	typedef struct packed {
		logic        valid;
		fetch_line_t data;
	} fetch_mem_rsp_t;

	typedef struct packed {
		fetch_pc_t [`FETCH_SLOTS-1:0] slot_pc;
		fetch_line_t                  line;
		fetch_irq_t                   irq;
		logic                         irqf;
	} fetch_bundle_t;

	// Miss fill sequencer of the instruction cache
	typedef enum logic [1:0] {
		IDLE,
		REQ,
		WAIT
	} fill_state_t;

endpackage

`default_nettype wire

// File: rtl/fetch_pc_gen.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_pc_gen (
	input  wire logic                       clk,
	input  wire logic                       rst,
	input  wire fetch_pkg::fetch_redirect_t redirect_i,
	input  wire logic                       hit_i,
	input  wire logic                       credit_ok_i,
	output fetch_pkg::fetch_pc_t            pc_o,
	output logic                            advance_o
);

	import fetch_pkg::*;

	// Distance between two sequential fetches in bytes
	localparam fetch_addr_t line_bytes = fetch_addr_t'(`FETCH_LINE_W / 8);

	// Current fetch PC and its next value
	fetch_pc_t pc_q;
	fetch_pc_t pc_d;

	// ========================================
	// Advance decision
	// ========================================
	// A line is taken only when the cache has it and decode has a free entry
	// The stage and the credit counter both use this as their only enable
	assign advance_o = hit_i && credit_ok_i;

	// ========================================
	// Next PC selection
	// ========================================
	always_comb begin
		pc_d = pc_q;
		// A redirect wins over everything else
		// It is taken even on a cycle where the current line also advances
		if (redirect_i.valid) begin
			pc_d = redirect_i.target;
		end else if (advance_o) begin
			// Sequential fetch moves one line ahead
			// Both branch numbers stay with the path being followed
			pc_d.pc = pc_q.pc + line_bytes;
		end
	end

	// PC register
	always_ff @(posedge clk) begin
		if (rst) begin
			// Fetch starts at the reset vector on branch number one
			pc_q.pc    <= `FETCH_RST_PC;
			pc_q.bno_t <= fetch_bno_t'(1);
			pc_q.bno_f <= fetch_bno_t'(1);
		end else begin
			pc_q <= pc_d;
		end
	end

	// The cache looks up this address in the same cycle
	assign pc_o = pc_q;

endmodule

`default_nettype wire

// File: rtl/fetch_icache.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_icache (
	input  wire logic                      clk,
	input  wire logic                      rst,
	input  wire fetch_pkg::fetch_pc_t      pc_i,
	input  wire logic                      flush_fill_i,
	output logic                           hit_o,
	output fetch_pkg::fetch_line_t         line_o,
	output fetch_pkg::fetch_mem_req_t      mem_req_o,
	input  wire fetch_pkg::fetch_mem_rsp_t mem_rsp_i
);

	import fetch_pkg::*;

	// ========================================
	// Storage
	// ========================================
	fetch_line_t                data_mem [`FETCH_IC_LINES];
	fetch_ic_tag_t              tag_mem [`FETCH_IC_LINES];
	logic [`FETCH_IC_LINES-1:0] valid_q;

	// Lookup fields taken from the fetch address
	fetch_ic_idx_t look_idx;
	fetch_ic_tag_t look_tag;

	// Fill control
	fill_state_t   state_q;
	fill_state_t   state_d;
	logic          drop_q;
	logic          fill_busy;
	logic          fill_done;
	fetch_addr_t   fill_addr_q;
	fetch_ic_idx_t fill_idx;
	fetch_ic_tag_t fill_tag;

	// ========================================
	// Hit lookup
	// ========================================
	assign look_idx = pc_i.pc[`FETCH_LINE_OFS_W +: `FETCH_IC_IDX_W];
	assign look_tag = pc_i.pc[`FETCH_ADDR_W-1:`FETCH_LINE_OFS_W+`FETCH_IC_IDX_W];

	// Purely combinational so a hit can advance in the same cycle
	assign hit_o  = valid_q[look_idx] && (tag_mem[look_idx] == look_tag);
	assign line_o = data_mem[look_idx];

	// ========================================
	// Miss fill
	// ========================================
	assign fill_idx  = fill_addr_q[`FETCH_LINE_OFS_W +: `FETCH_IC_IDX_W];
	assign fill_tag  = fill_addr_q[`FETCH_ADDR_W-1:`FETCH_LINE_OFS_W+`FETCH_IC_IDX_W];
	assign fill_busy = (state_q != IDLE);

	// A response is only written when the fill was not cancelled in the same cycle
	assign fill_done = (state_q == WAIT) && mem_rsp_i.valid && !flush_fill_i;

	// Request stays up from REQ until its response arrives
	assign mem_req_o.valid = fill_busy;
	assign mem_req_o.addr  = fill_addr_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				// No new fill while a cancelled one still owes a response
				if (!hit_o && !drop_q) begin
					state_d = REQ;
				end
			end
			REQ: begin
				state_d = WAIT;
			end
			WAIT: begin
				if (mem_rsp_i.valid) begin
					state_d = IDLE;
				end
			end
			default: begin
				state_d = IDLE;
			end
		endcase
		// A redirect abandons the current fill
		if (flush_fill_i) begin
			state_d = IDLE;
		end
	end

	// Control state and line valid bits
	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= IDLE;
			drop_q  <= 1'b0;
			valid_q <= '0;
		end else begin
			state_q <= state_d;
			// Remember that the next response belongs to a cancelled request
			if (flush_fill_i && fill_busy && !((state_q == WAIT) && mem_rsp_i.valid)) begin
				drop_q <= 1'b1;
			end else if (drop_q && mem_rsp_i.valid) begin
				drop_q <= 1'b0;
			end
			if (fill_done) begin
				valid_q[fill_idx] <= 1'b1;
			end
		end
	end

	// Fill address and array writes
	always_ff @(posedge clk) begin
		if ((state_q == IDLE) && (state_d == REQ)) begin
			fill_addr_q <= {pc_i.pc[`FETCH_ADDR_W-1:`FETCH_LINE_OFS_W], {`FETCH_LINE_OFS_W{1'b0}}};
		end
		if (fill_done) begin
			data_mem[fill_idx] <= mem_rsp_i.data;
			tag_mem[fill_idx]  <= fill_tag;
		end
	end

endmodule

`default_nettype wire

// File: rtl/fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_stage (
	input  wire logic                   clk,
	input  wire logic                   rst,
	input  wire logic                   advance_i,
	input  wire fetch_pkg::fetch_pc_t   pc_i,
	input  wire fetch_pkg::fetch_line_t line_i,
	input  wire logic                   stomp_i,
	input  wire fetch_pkg::fetch_bno_t  stomp_bno_i,
	input  wire logic                   nmi_i,
	input  wire fetch_pkg::fetch_irq_t  irq_i,
	input  wire logic                   irqf_i,
	output fetch_pkg::fetch_bundle_t    bundle_o
);

	import fetch_pkg::*;

	// Line of valid NOPs used whenever fetched code must not execute
	localparam fetch_line_t nop_line = {`FETCH_SLOTS{`FETCH_OP_NOP}};

	// Bytes per instruction slot
	localparam fetch_addr_t slot_bytes = fetch_addr_t'(`FETCH_SLOT_W / 8);

	fetch_pc_t [`FETCH_SLOTS-1:0] slot_pc;
	fetch_pc_t [`FETCH_SLOTS-1:0] slot_pc_q;
	fetch_line_t                  line_q;
	fetch_irq_t                   irq_q;
	logic                         irqf_q;
	logic [`FETCH_RSTCNT_W-1:0]   rstcnt_q;
	logic                         rst_busy;
	logic                         squash;

	// ========================================
	// Slot addresses
	// ========================================
	// Every slot keeps the branch numbers of the line it came from
	always_comb begin
		for (int i = 0; i < `FETCH_SLOTS; i++) begin
			slot_pc[i]    = pc_i;
			slot_pc[i].pc = pc_i.pc + slot_bytes * fetch_addr_t'(i);
		end
	end

	// ========================================
	// Squash conditions
	// ========================================
	// The counter starts with the first line taken after reset
	// and then runs one step per cycle until it saturates
	assign rst_busy = (rstcnt_q < `FETCH_RSTCNT_CYC);

	// Stomped branch numbers and a pending NMI also kill the line
	assign squash = rst_busy || (stomp_i && (pc_i.bno_t != stomp_bno_i)) || nmi_i;

	// Control state: reset counter and interrupt capture
	always_ff @(posedge clk) begin
		if (rst) begin
			rstcnt_q <= '0;
			irq_q    <= '0;
			irqf_q   <= 1'b0;
		end else begin
			if (rst_busy && (advance_i || (rstcnt_q != '0))) begin
				rstcnt_q <= rstcnt_q + 1'b1;
			end
			// Interrupt state is sampled together with the line
			if (advance_i) begin
				irq_q  <= irq_i;
				irqf_q <= irqf_i;
			end
		end
	end

	// Payload registers load only when a line is taken
	always_ff @(posedge clk) begin
		if (advance_i) begin
			slot_pc_q <= slot_pc;
			line_q    <= squash ? nop_line : line_i;
		end
	end

	always_comb begin
		bundle_o.slot_pc = slot_pc_q;
		bundle_o.line    = line_q;
		bundle_o.irq     = irq_q;
		bundle_o.irqf    = irqf_q;
	end

endmodule

`default_nettype wire

// File: rtl/fetch_credit_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_credit_ctrl (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic advance_i,
	input  wire logic credit_return_i,
	output logic      credit_ok_o,
	output logic      bundle_valid_o
);

	import fetch_pkg::*;

	// Free entries in the decoder buffer
	fetch_credit_t count_q;

	// Registered copy of advance that marks the bundle as present
	logic valid_q;

	// ========================================
	// Credit counter
	// ========================================
	// Fetch may only proceed while decode has somewhere to put the bundle
	assign credit_ok_o = (count_q != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			// Decode starts with every buffer entry free
			count_q <= fetch_credit_t'(`FETCH_CREDITS);
			valid_q <= 1'b0;
		end else begin
			valid_q <= advance_i;
			// A send and a return in the same cycle cancel out
			case ({advance_i, credit_return_i})
				2'b10: begin
					count_q <= count_q - 1'b1;
				end
				2'b01: begin
					count_q <= count_q + 1'b1;
				end
				default: begin
					count_q <= count_q;
				end
			endcase
		end
	end

	// High for exactly the cycle after each advance
	assign bundle_valid_o = valid_q;

endmodule

`default_nettype wire

// File: rtl/fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_top (
	input  wire logic                       clk,
	input  wire logic                       rst,
	input  wire fetch_pkg::fetch_redirect_t redirect_i,
	input  wire logic                       stomp_i,
	input  wire fetch_pkg::fetch_bno_t      stomp_bno_i,
	input  wire logic                       nmi_i,
	input  wire fetch_pkg::fetch_irq_t      irq_i,
	input  wire logic                       irqf_i,
	output fetch_pkg::fetch_mem_req_t       mem_req_o,
	input  wire fetch_pkg::fetch_mem_rsp_t  mem_rsp_i,
	output logic                            bundle_valid_o,
	output fetch_pkg::fetch_bundle_t        bundle_o,
	input  wire logic                       credit_return_i
);

	import fetch_pkg::*;

	// ========================================
	// Internal wiring
	// ========================================
	fetch_pc_t   fetch_pc;
	fetch_line_t ic_line;
	logic        hit;
	logic        credit_ok;
	logic        advance;

	// Address selection and the single advance enable
	fetch_pc_gen u_pc_gen (
		.clk         (clk),
		.rst         (rst),
		.redirect_i  (redirect_i),
		.hit_i       (hit),
		.credit_ok_i (credit_ok),
		.pc_o        (fetch_pc),
		.advance_o   (advance)
	);

	// A redirect also cancels any fill in flight
	fetch_icache u_icache (
		.clk          (clk),
		.rst          (rst),
		.pc_i         (fetch_pc),
		.flush_fill_i (redirect_i.valid),
		.hit_o        (hit),
		.line_o       (ic_line),
		.mem_req_o    (mem_req_o),
		.mem_rsp_i    (mem_rsp_i)
	);

	fetch_stage u_stage (
		.clk         (clk),
		.rst         (rst),
		.advance_i   (advance),
		.pc_i        (fetch_pc),
		.line_i      (ic_line),
		.stomp_i     (stomp_i),
		.stomp_bno_i (stomp_bno_i),
		.nmi_i       (nmi_i),
		.irq_i       (irq_i),
		.irqf_i      (irqf_i),
		.bundle_o    (bundle_o)
	);

	// Flow control toward decode
	fetch_credit_ctrl u_credit (
		.clk             (clk),
		.rst             (rst),
		.advance_i       (advance),
		.credit_return_i (credit_return_i),
		.credit_ok_o     (credit_ok),
		.bundle_valid_o  (bundle_valid_o)
	);

endmodule

`default_nettype wire

// File: testbench/tb_fetch_model.svh
`ifndef TB_FETCH_MODEL_SVH
`define TB_FETCH_MODEL_SVH

// ========================================
// Reference model state
// ========================================
// Fetch PC the model expects for the line taken in the current cycle
fetch_pc_t exp_pc;

// Cycles of the post reset squash window already used
int rstcnt;

// Bundles sent to decode whose credit has not come back yet
int outstanding;

int mismatch_errs;
int other_errs;

// Every memory word holds its own byte address XOR a fixed mask
function automatic fetch_line_t rule_line(input fetch_addr_t base);
	fetch_line_t l;
	for (int i = 0; i < `FETCH_SLOTS; i++) begin
		l[i] = fetch_insn_t'((base + fetch_addr_t'(4 * i)) ^ 32'hA5A5_0000);
	end
	return l;
endfunction

// ========================================
// Compare tasks
// ========================================
task automatic check_pc(input string name, input fetch_pc_t got, input fetch_pc_t exp);
	if (got !== exp) begin
		mismatch_errs++;
		$display("MISMATCH %s at cycle %0d: got 0x%h expected 0x%h", name, cyc, got, exp);
	end
endtask

task automatic check_line(input string name, input fetch_line_t got, input fetch_line_t exp);
	if (got !== exp) begin
		mismatch_errs++;
		$display("MISMATCH %s at cycle %0d: got 0x%h expected 0x%h", name, cyc, got, exp);
	end
endtask

task automatic check_addr(input string name, input fetch_addr_t got, input fetch_addr_t exp);
	if (got !== exp) begin
		mismatch_errs++;
		$display("MISMATCH %s at cycle %0d: got 0x%h expected 0x%h", name, cyc, got, exp);
	end
endtask

task automatic check_irq(input string name, input fetch_irq_t got, input fetch_irq_t exp);
	if (got !== exp) begin
		mismatch_errs++;
		$display("MISMATCH %s at cycle %0d: got 0x%h expected 0x%h", name, cyc, got, exp);
	end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		mismatch_errs++;
		$display("MISMATCH %s at cycle %0d: got 0x%h expected 0x%h", name, cyc, got, exp);
	end
endtask

// Counts are checked against an upper bound
task automatic check_count(input string name, input int got, input int limit);
	if (got > limit) begin
		mismatch_errs++;
		$display("MISMATCH %s at cycle %0d: got 0x%h limit 0x%h", name, cyc, got, limit);
	end
endtask

// ========================================
// Per cycle prediction
// ========================================
// Called on the falling edge while the inputs of the cycle that just ended are still driven
task automatic observe_outputs();
	fetch_pc_t   slot_exp;
	fetch_line_t exp_line;
	logic        squash;
	if (bundle_valid) begin
		// The line cannot be in the cache before memory answered once
		if (rsp_count == 0) begin
			other_errs++;
			$display("ERROR: a bundle arrived at cycle %0d before any cache fill", cyc);
		end
		squash = (rstcnt < `FETCH_RSTCNT_CYC) || nmi || (stomp && (exp_pc.bno_t != stomp_bno));
		for (int i = 0; i < `FETCH_SLOTS; i++) begin
			slot_exp    = exp_pc;
			slot_exp.pc = exp_pc.pc + fetch_addr_t'(4 * i);
			check_pc($sformatf("bundle.slot_pc[%0d]", i), bundle.slot_pc[i], slot_exp);
		end
		exp_line = squash ? {`FETCH_SLOTS{`FETCH_OP_NOP}} : rule_line(exp_pc.pc);
		check_line("bundle.line", bundle.line, exp_line);
		check_irq("bundle.irq", bundle.irq, irq);
		check_flag("bundle.irqf", bundle.irqf, irqf);
		outstanding++;
		check_count("credits_in_use", outstanding, `FETCH_CREDITS);
		bundles_seen++;
	end
	// The squash window opens with the first line taken and then runs every cycle
	if ((rstcnt < `FETCH_RSTCNT_CYC) && (bundle_valid || (rstcnt != 0))) begin
		rstcnt++;
	end
	// A redirect replaces the PC even when a line was taken in the same cycle
	if (redirect.valid) begin
		exp_pc = redirect.target;
	end else if (bundle_valid) begin
		exp_pc.pc = exp_pc.pc + fetch_addr_t'(16);
	end
endtask

`endif

// File: testbench/tb_fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_consts.svh"

module tb_fetch_top;

	import fetch_pkg::*;

	localparam int num_bundles = 400;
	localparam int run_limit   = 20000;

	// ========================================
	// DUT signals
	// ========================================
	logic            clk;
	logic            rst;
	fetch_redirect_t redirect;
	logic            stomp;
	fetch_bno_t      stomp_bno;
	logic            nmi;
	fetch_irq_t      irq;
	logic            irqf;
	fetch_mem_req_t  mem_req;
	fetch_mem_rsp_t  mem_rsp;
	logic            bundle_valid;
	fetch_bundle_t   bundle;
	logic            credit_return;

	int          cyc;
	int          bundles_seen;
	int          rsp_count;
	logic        rsp_busy;
	int          rsp_wait;
	fetch_addr_t rsp_addr;
	// Cycle numbers at which a credit is due back from decode
	int          credit_due[$];

	`include "tb_fetch_model.svh"

	fetch_top dut (
		.clk             (clk),
		.rst             (rst),
		.redirect_i      (redirect),
		.stomp_i         (stomp),
		.stomp_bno_i     (stomp_bno),
		.nmi_i           (nmi),
		.irq_i           (irq),
		.irqf_i          (irqf),
		.mem_req_o       (mem_req),
		.mem_rsp_i       (mem_rsp),
		.bundle_valid_o  (bundle_valid),
		.bundle_o        (bundle),
		.credit_return_i (credit_return)
	);

	always #4 clk = ~clk;

	// Memory answers each request once and 1 to 8 cycles after it saw it
	task automatic respond_memory();
		mem_rsp.valid = 1'b0;
		if (rsp_busy) begin
			rsp_wait--;
			if (rsp_wait == 0) begin
				mem_rsp.valid = 1'b1;
				mem_rsp.data  = rule_line(rsp_addr);
				rsp_busy      = 1'b0;
				rsp_count++;
			end
		end else if (mem_req.valid) begin
			// A fill asks for the aligned line that holds the stalled fetch PC
			check_addr("mem_req_o.addr", mem_req.addr, exp_pc.pc & ~fetch_addr_t'(15));
			rsp_busy = 1'b1;
			rsp_addr = mem_req.addr;
			rsp_wait = 1 + ($urandom % 8);
		end
	endtask

	// Decode frees each entry 0 to 5 cycles after the bundle
	// At most one entry is freed per cycle
	task automatic return_credits(input logic new_bundle);
		int idx;
		idx = -1;
		if (new_bundle) begin
			credit_due.push_back(cyc + ($urandom % 6));
		end
		credit_return = 1'b0;
		foreach (credit_due[i]) begin
			if ((idx < 0) && (credit_due[i] <= cyc)) begin
				idx = i;
			end
		end
		if (idx >= 0) begin
			credit_due.delete(idx);
			credit_return = 1'b1;
			outstanding--;
		end
	endtask

	// Back end events come at low rates
	// Redirect targets are line aligned in a small window so lines get revisited
	task automatic drive_random_inputs();
		redirect.valid        = (($urandom % 32) == 0);
		redirect.target.pc    = fetch_addr_t'(`FETCH_RST_PC) + fetch_addr_t'(($urandom % 64) * 16);
		redirect.target.bno_t = fetch_bno_t'(1 + ($urandom % 3));
		redirect.target.bno_f = fetch_bno_t'($urandom);
		stomp                 = (($urandom % 16) == 0);
		stomp_bno             = fetch_bno_t'(1 + ($urandom % 3));
		nmi                   = (($urandom % 32) == 0);
		irq                   = fetch_irq_t'($urandom);
		irqf                  = (($urandom % 8) == 0);
	endtask

	// Each cycle first checks what the last rising edge produced and then drives the next inputs
	task automatic run_cycle();
		@(negedge clk);
		cyc++;
		observe_outputs();
		respond_memory();
		return_credits(bundle_valid);
		drive_random_inputs();
	endtask

	// ========================================
	// Main sequence
	// ========================================
	initial begin
		void'($urandom(3));
		clk           = 1'b0;
		rst           = 1'b1;
		redirect      = '0;
		stomp         = 1'b0;
		stomp_bno     = '0;
		nmi           = 1'b0;
		irq           = '0;
		irqf          = 1'b0;
		mem_rsp       = '0;
		credit_return = 1'b0;
		cyc           = 0;
		bundles_seen  = 0;
		rsp_count     = 0;
		rsp_busy      = 1'b0;
		rsp_wait      = 0;
		rsp_addr      = '0;
		outstanding   = 0;
		rstcnt        = 0;
		mismatch_errs = 0;
		other_errs    = 0;
		exp_pc.pc     = `FETCH_RST_PC;
		exp_pc.bno_t  = fetch_bno_t'(1);
		exp_pc.bno_f  = fetch_bno_t'(1);
		repeat (10) @(negedge clk);
		// Everything toward decode and memory is quiet in reset
		check_flag("bundle_valid_o", bundle_valid, 1'b0);
		check_flag("mem_req_o.valid", mem_req.valid, 1'b0);
		check_irq("bundle.irq", bundle.irq, '0);
		check_flag("bundle.irqf", bundle.irqf, 1'b0);
		rst = 1'b0;
		while ((bundles_seen < num_bundles) && (cyc < run_limit)) begin
			run_cycle();
		end
		if (bundles_seen < num_bundles) begin
			other_errs++;
			$display("ERROR: timeout after %0d cycles with only %0d bundles received",
				cyc, bundles_seen);
		end
		$display("errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
		if ((mismatch_errs == 0) && (other_errs == 0)) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+rtl
+incdir+testbench
rtl/fetch_pkg.sv
rtl/fetch_pc_gen.sv
rtl/fetch_icache.sv
rtl/fetch_stage.sv
rtl/fetch_credit_ctrl.sv
rtl/fetch_top.sv
testbench/tb_fetch_top.sv

// File: Bender.yml
package:
  name: fetch

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/fetch_pkg.sv
      - rtl/fetch_pc_gen.sv
      - rtl/fetch_icache.sv
      - rtl/fetch_stage.sv
      - rtl/fetch_credit_ctrl.sv
      - rtl/fetch_top.sv
  - target: simulation
    include_dirs:
      - rtl
      - testbench
    files:
      - testbench/tb_fetch_top.sv
